// File: Makefile
TOP = axis_ingress_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
	  echo "TEST FAILED"; exit 1; \
	else \
	  echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: verif/axis_ingress_asserts.sv
/* Stream ingress assertions */
`default_nettype none

module axis_ingress_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input axis_pkg::axis_beat_t axis_in,
  input axis_pkg::axis_rdy_t  axis_rdy,
  input logic                 rd,
  input logic                 empty,
  input logic                 fifo_wen,
  input logic                 fifo_full
);

  timeunit 1ns;
  timeprecision 100ps;

  // Register stage never pushes into a full FIFO
  write_not_full: assert property (
    @(posedge clk) disable iff (!rst_n) fifo_wen |-> !fifo_full
  ) else $error("FIFO written while full");

  flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(empty && fifo_full)
  ) else $error("FIFO empty and full at the same time");

  // Stalled beat is held by the source
  held_beat: assert property (
    @(posedge clk) disable iff (!rst_n)
    axis_in.tvalid && !axis_rdy.tready |=> axis_in.tvalid && $stable(axis_in)
  ) else $error("Stream beat changed while stalled");

  no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n) rd |-> !empty
  ) else $error("Read strobe raised while FIFO empty");

endmodule

`default_nettype wire

// File: verif/axis_ingress_tb.sv
/* Stream ingress testbench */
`include "axis_consts.svh"
`default_nettype none

module axis_ingress_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import axis_pkg::*;
  import apb_pkg::*;

  localparam int NUM_RAND    = 400;
  localparam int NUM_BURST   = `FIFO_DEPTH + 6;
  localparam int NUM_AFTER   = 12;
  localparam int TOTAL_BEATS = NUM_RAND + NUM_BURST + NUM_AFTER;
  localparam int LEVEL_W     = $clog2(`FIFO_DEPTH + 1);

  logic        clk;
  logic        rst_n;
  axis_beat_t  axis_in;
  axis_rdy_t   axis_rdy;
  logic        rd;
  axis_beat_t  rd_beat;
  logic        empty;
  logic        aempty;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  integer      seed;
  integer      rd_seed;
  logic [31:0] rd_rand;
  int          errors;
  int          rd_mode;
  int          beat_tally;
  int          frame_tally;
  int          pop_count;
  logic        burst_done;
  axis_beat_t  model_q[$];

  axis_ingress_top axis_ingress_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .axis_in  (axis_in),
    .axis_rdy (axis_rdy),
    .rd       (rd),
    .rd_beat  (rd_beat),
    .empty    (empty),
    .aempty   (aempty),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp)
  );

  bind axis_ingress_top axis_ingress_asserts axis_ingress_asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .axis_in   (axis_in),
    .axis_rdy  (axis_rdy),
    .rd        (rd),
    .empty     (empty),
    .fifo_wen  (fifo_wen),
    .fifo_full (fifo_full)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic axis_beat_t expected_head();
    return model_q[0];
  endfunction

  // Flag bits follow the FIFO threshold rules
  function automatic logic [31:0] expected_status(input int lvl);
    logic [31:0] w;
    w = '0;
    w[0] = (lvl == 0);
    w[1] = (lvl <= `FIFO_AEMPTY_VAL);
    w[2] = ((`FIFO_DEPTH - lvl) <= `FIFO_AFULL_VAL);
    w[3] = (lvl == `FIFO_DEPTH);
    w[8 +: LEVEL_W] = lvl[LEVEL_W-1:0];
    return w;
  endfunction

  function automatic axis_beat_t rand_beat();
    axis_beat_t  b;
    logic [31:0] r;
    r = $random(seed);
    b.tvalid = 1'b1;
    b.tdata  = $random(seed);
    b.tuser  = r[3:0];
    b.tlast  = (r[7:5] == 3'd0);
    return b;
  endfunction

  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    assert (act == exp)
    else
    begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // Setup phase then access phase with prdata taken mid access
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    apb_req         = '0;
    apb_req.psel    = 1'b1;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic check_reg(input string name, input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_access(1'b0, addr, '0, data, err);
    assert (!err)
    else
    begin
      errors++;
      $display("APB read of %s returned a slave error", name);
    end
    check_value({"prdata ", name}, data, exp);
  endtask

  task automatic check_counts();
    check_reg("BEATS", `CSR_BEATS, beat_tally);
    check_reg("FRAMES", `CSR_FRAMES, frame_tally);
    check_reg("STATUS", `CSR_STATUS, expected_status(model_q.size()));
  endtask

  // Holds the beat until a cycle with tready high
  task automatic send_beat(input axis_beat_t b);
    logic taken;
    axis_in = b;
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      taken = axis_rdy.tready;
      @(posedge clk);
      #1;
    end
    axis_in = '0;
  endtask

  task automatic send_stream(input int n, input bit gaps);
    logic [31:0] r;
    for (int i = 0; i < n; i++)
    begin
      send_beat(rand_beat());
      r = $random(seed);
      if (gaps)
        repeat (r[1:0])
        begin
          @(posedge clk);
          #1;
        end
    end
  endtask

  task automatic wait_for_level(input int target, input int max_cycles);
    int n;
    n = 0;
    while (model_q.size() != target && n < max_cycles)
    begin
      @(posedge clk);
      n++;
    end
    @(posedge clk);
    #1;
    assert (model_q.size() == target)
    else
    begin
      errors++;
      $display("Model level did not reach %0d within %0d cycles", target, max_cycles);
    end
  endtask

  // Consumer pops only while the FIFO holds data
  always
  begin
    @(posedge clk);
    #1;
    rd_rand = $random(rd_seed);
    case (rd_mode)
      1:       rd = rd_rand[0] & ~empty;
      2:       rd = ~empty;
      default: rd = 1'b0;
    endcase
  end

  // Inputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (rd && !empty)
      begin
        assert (model_q.size() > 0)
        else
        begin
          errors++;
          $display("Beat popped while the model expected none");
        end
        if (model_q.size() > 0)
        begin
          assert (rd_beat == expected_head())
          else
          begin
            errors++;
            $display("Fail rd_beat: expected %h, got %h", expected_head(), rd_beat);
          end
          void'(model_q.pop_front());
          pop_count++;
        end
      end
      if (axis_in.tvalid && axis_rdy.tready)
      begin
        model_q.push_back(axis_in);
        beat_tally++;
        if (axis_in.tlast)
          frame_tally++;
      end
    end
  end

  initial
  begin
    repeat (TOTAL_BEATS * 20 + 2000) @(posedge clk);
    errors++;
    $display("Timeout: run did not finish within %0d cycles", TOTAL_BEATS * 20 + 2000);
    $display("Summary: %0d errors", errors);
    $display("Errors found");
    $finish;
  end

  initial
  begin
    logic [31:0] data;
    logic        err;
    seed        = 32'hb748_84fa;
    rd_seed     = ~seed;
    rst_n       = 1'b0;
    axis_in     = '0;
    rd          = 1'b0;
    apb_req     = '0;
    errors      = 0;
    rd_mode     = 0;
    beat_tally  = 0;
    frame_tally = 0;
    pop_count   = 0;
    burst_done  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_value("tready", 32'(axis_rdy.tready), 1);
    check_value("empty", 32'(empty), 1);
    check_value("aempty", 32'(aempty), 1);
    check_value("pready", 32'(apb_rsp.pready), 1);
    check_reg("STATUS", `CSR_STATUS, expected_status(0));
    check_reg("BEATS", `CSR_BEATS, 0);
    check_reg("FRAMES", `CSR_FRAMES, 0);

    // Random traffic with random pops
    rd_mode = 1;
    send_stream(NUM_RAND, 1'b1);
    rd_mode = 2;
    wait_for_level(0, 200);
    check_counts();

    // Burst into a stalled consumer
    rd_mode = 0;
    fork
      begin
        send_stream(NUM_BURST, 1'b0);
        burst_done = 1'b1;
      end
    join_none
    wait_for_level(`FIFO_DEPTH, 200);
    repeat (4)
    begin
      @(posedge clk);
      #1;
    end
    check_value("tready", 32'(axis_rdy.tready), 0);
    check_value("model level", model_q.size(), `FIFO_DEPTH);
    check_reg("STATUS", `CSR_STATUS, expected_status(`FIFO_DEPTH));
    rd_mode = 2;
    wait (burst_done);
    wait_for_level(0, 200);
    check_counts();

    // Counter clear then counting restarts
    apb_access(1'b1, `CSR_CTRL, 32'h1, data, err);
    check_value("pslverr", 32'(err), 0);
    beat_tally  = 0;
    frame_tally = 0;
    check_counts();
    check_reg("CTRL", `CSR_CTRL, 0);
    send_stream(NUM_AFTER, 1'b1);
    wait_for_level(0, 200);
    check_counts();
    apb_access(1'b0, 4'h2, '0, data, err);
    check_value("pslverr", 32'(err), 1);
    check_value("pop count", pop_count, TOTAL_BEATS);

    $display("Summary: %0d errors", errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/axis_pkg.sv
verilog/apb_pkg.sv
verilog/stream_fifo.sv
verilog/axis_ingress_slv.sv
verilog/ingress_csr.sv
verilog/axis_ingress_top.sv
verif/axis_ingress_asserts.sv
verif/axis_ingress_tb.sv

// File: verilog/apb_pkg.sv
/* APB request and response types */
`default_nettype none

package apb_pkg;

  // Master to slave
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // Slave to master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: verilog/axis_consts.svh
/* Stream ingress constants */
`ifndef AXIS_CONSTS_SVH
`define AXIS_CONSTS_SVH

`default_nettype none

// Stream payload widths
`define AXIS_DATA_W 32
`define AXIS_USER_W 4

// FIFO sizing
`define FIFO_DEPTH 16

// Almost-full when free entries drop to this many or fewer
`define FIFO_AFULL_VAL 1

// Almost-empty when occupied entries drop to this many or fewer
`define FIFO_AEMPTY_VAL 1

// APB register byte offsets
`define CSR_STATUS 4'h0
`define CSR_BEATS 4'h4
`define CSR_FRAMES 4'h8
`define CSR_CTRL 4'hC

`default_nettype wire

`endif

// File: verilog/axis_ingress_slv.sv
/* Stream slave register stage */
`default_nettype none

module axis_ingress_slv (
  input  logic                 clk,
  input  logic                 rst_n,
  input  axis_pkg::axis_beat_t axis_in,
  output axis_pkg::axis_rdy_t  axis_rdy,
  input  logic                 afull,
  output axis_pkg::axis_beat_t wdata,
  output logic                 wen
);

  import axis_pkg::*;

  axis_beat_t beat_q;
  logic       accept;

  // Almost-full leaves room for the beat held in the stage
  assign axis_rdy.tready = ~afull;
  assign accept = axis_in.tvalid & axis_rdy.tready;

  // Payload sampled every cycle, only committed with wen
  always_ff @(posedge clk)
  begin
    beat_q <= axis_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wen <= 1'b0;
    else
      wen <= accept;
  end

  assign wdata = beat_q;

endmodule

`default_nettype wire

// File: verilog/axis_ingress_top.sv
/* Stream ingress buffer top level */
`include "axis_consts.svh"
`default_nettype none

module axis_ingress_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  axis_pkg::axis_beat_t axis_in,
  output axis_pkg::axis_rdy_t  axis_rdy,
  input  logic                 rd,
  output axis_pkg::axis_beat_t rd_beat,
  output logic                 empty,
  output logic                 aempty,
  input  apb_pkg::apb_req_t    apb_req,
  output apb_pkg::apb_rsp_t    apb_rsp
);

  import axis_pkg::*;

  localparam int unsigned BEAT_W  = $bits(axis_beat_t);
  localparam int unsigned LEVEL_W = $clog2(`FIFO_DEPTH + 1);

  axis_beat_t         fifo_wdata;
  logic               fifo_wen;
  logic               fifo_full;
  logic               fifo_afull;
  logic [LEVEL_W-1:0] fifo_level;

  // Register stage in front of the FIFO
  axis_ingress_slv axis_ingress_slv_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .axis_in  (axis_in),
    .axis_rdy (axis_rdy),
    .afull    (fifo_afull),
    .wdata    (fifo_wdata),
    .wen      (fifo_wen)
  );

  stream_fifo #(
    .WIDTH      (BEAT_W),
    .DEPTH      (`FIFO_DEPTH),
    .AFULL_VAL  (`FIFO_AFULL_VAL),
    .AEMPTY_VAL (`FIFO_AEMPTY_VAL),
    .LEVEL_W    (LEVEL_W)
  ) stream_fifo_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .wdata  (fifo_wdata),
    .wen    (fifo_wen),
    .ren    (rd),
    .rdata  (rd_beat),
    .full   (fifo_full),
    .afull  (fifo_afull),
    .empty  (empty),
    .aempty (aempty),
    .level  (fifo_level)
  );

  // Counts follow the FIFO write strobe
  ingress_csr #(
    .LEVEL_W (LEVEL_W)
  ) ingress_csr_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .wen     (fifo_wen),
    .wlast   (fifo_wdata.tlast),
    .level   (fifo_level),
    .full    (fifo_full),
    .afull   (fifo_afull),
    .empty   (empty),
    .aempty  (aempty)
  );

endmodule

`default_nettype wire

// File: verilog/axis_pkg.sv
/* Stream beat types */
`include "axis_consts.svh"
`default_nettype none

package axis_pkg;

  // One stream beat, 38 bits with the default widths
  typedef struct packed {
    logic                    tvalid;
    logic [`AXIS_DATA_W-1:0] tdata;
    logic [`AXIS_USER_W-1:0] tuser;
    logic                    tlast;
  } axis_beat_t;

  // Back-channel toward the source
  typedef struct packed {
    logic tready;
  } axis_rdy_t;

endpackage

`default_nettype wire

// File: verilog/ingress_csr.sv
/* Ingress status and counter registers */
`include "axis_consts.svh"
`default_nettype none

module ingress_csr #(
  parameter int unsigned LEVEL_W = $clog2(`FIFO_DEPTH + 1)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  apb_pkg::apb_req_t  apb_req,
  output apb_pkg::apb_rsp_t  apb_rsp,
  input  logic               wen,
  input  logic               wlast,
  input  logic [LEVEL_W-1:0] level,
  input  logic               full,
  input  logic               afull,
  input  logic               empty,
  input  logic               aempty
);

  logic        access;
  logic        wr_access;
  logic        addr_hit;
  logic        cnt_clr;
  logic [31:0] beat_cnt;
  logic [31:0] frame_cnt;
  logic [31:0] status;
  logic [31:0] rd_data;

  // Access phase of an APB transfer
  assign access    = apb_req.psel & apb_req.penable;
  assign wr_access = access & apb_req.pwrite;

  // CTRL bit 0 clears both counters
  assign cnt_clr = wr_access & (apb_req.paddr == `CSR_CTRL) & apb_req.pwdata[0];

  // STATUS layout
  // bit 0 empty, bit 1 aempty, bit 2 afull, bit 3 full, level from bit 8
  always_comb
  begin
    status = '0;
    status[3:0] = {full, afull, aempty, empty};
    status[8 +: LEVEL_W] = level;
  end

  // Counters track what enters the FIFO
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      beat_cnt  <= '0;
      frame_cnt <= '0;
    end
    else if (cnt_clr)
    begin
      beat_cnt  <= '0;
      frame_cnt <= '0;
    end
    else if (wen)
    begin
      beat_cnt <= beat_cnt + 1'b1;
      if (wlast)
        frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // Read mux and address decode
  always_comb
  begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (apb_req.paddr)
      `CSR_STATUS: rd_data = status;
      `CSR_BEATS:  rd_data = beat_cnt;
      `CSR_FRAMES: rd_data = frame_cnt;
      `CSR_CTRL:   rd_data = '0;
      default:     addr_hit = 1'b0;
    endcase
  end

  // No wait states
  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & ~addr_hit;

endmodule

`default_nettype wire

// File: verilog/stream_fifo.sv
/* Flop-based synchronous FIFO */
`default_nettype none

module stream_fifo #(
  parameter int unsigned WIDTH      = 38,
  parameter int unsigned DEPTH      = 16,
  parameter int unsigned AFULL_VAL  = 1,
  parameter int unsigned AEMPTY_VAL = 1,
  parameter int unsigned LEVEL_W    = $clog2(DEPTH + 1)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [WIDTH-1:0]   wdata,
  input  logic               wen,
  input  logic               ren,
  output logic [WIDTH-1:0]   rdata,
  output logic               full,
  output logic               afull,
  output logic               empty,
  output logic               aempty,
  output logic [LEVEL_W-1:0] level
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [LEVEL_W-1:0] DEPTH_L = LEVEL_W'(DEPTH);

  logic [WIDTH-1:0]   mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [LEVEL_W-1:0] count;
  logic [LEVEL_W-1:0] free_cnt;
  logic               do_wr;
  logic               do_rd;

  // Wrap at DEPTH, so non power-of-two depths work too
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  // Overflow and underflow are dropped here
  assign do_wr = wen & ~full;
  assign do_rd = ren & ~empty;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd)
        rd_ptr <= ptr_inc(rd_ptr);
      // Read and write together keep the level
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
  end

  // Head entry is always visible
  assign rdata = mem[rd_ptr];

  assign level    = count;
  assign free_cnt = DEPTH_L - count;
  assign full     = (count == DEPTH_L);
  assign empty    = (count == '0);
  assign afull    = (free_cnt <= LEVEL_W'(AFULL_VAL));
  assign aempty   = (count <= LEVEL_W'(AEMPTY_VAL));

endmodule

`default_nettype wire
